//--- rtl/core_pkg.sv
package core_pkg;

	// ##########################################################################
	// Instruction word
	// ##########################################################################

	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'b0000011,
		OPCODE_OP_IMM = 7'b0010011,
		OPCODE_AUIPC  = 7'b0010111,
		OPCODE_STORE  = 7'b0100011,
		OPCODE_OP     = 7'b0110011,
		OPCODE_LUI    = 7'b0110111,
		OPCODE_BRANCH = 7'b1100011,
		OPCODE_JALR   = 7'b1100111,
		OPCODE_JAL    = 7'b1101111,
		OPCODE_SYSTEM = 7'b1110011
	} opcode_t;

	// Each view lays its own fields over the same 32 bits.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_t    opcode;
		} common;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			opcode_t     opcode;
		} itype;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			opcode_t    opcode;
		} stype;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			opcode_t    opcode;
		} btype;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			opcode_t     opcode;
		} utype;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			opcode_t    opcode;
		} jtype;
	} instr_t;

	// ##########################################################################
	// Selects and operations
	// ##########################################################################

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS2
	} alu_op_t;

	// Branch encodings follow funct3 so a branch can cast it directly.
	typedef enum logic [2:0] {
		CMP_EQ     = 3'b000,
		CMP_NE     = 3'b001,
		CMP_NEVER  = 3'b010,
		CMP_ALWAYS = 3'b011,
		CMP_LT     = 3'b100,
		CMP_GE     = 3'b101,
		CMP_LTU    = 3'b110,
		CMP_GEU    = 3'b111
	} cmp_op_t;

	typedef enum logic {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_PC
	} alu_in1_sel_t;

	typedef enum logic [1:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IMM,
		ALU_IN2_SEL_CSR_OUT
	} alu_in2_sel_t;

	typedef enum logic [1:0] {
		WR_SEL_ALU_OUT,
		WR_SEL_PC_4,
		WR_SEL_DMEM_RD_DATA
	} wr_sel_t;

	typedef enum logic [1:0] {
		BYPASS_NONE,
		BYPASS_EX,
		BYPASS_MEM,
		BYPASS_WB
	} bypass_t;

	typedef enum logic {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT
	} next_pc_sel_t;

	typedef struct packed {
		logic         regfile_we;
		alu_op_t      alu_op;
		alu_in1_sel_t alu_in1_sel;
		alu_in2_sel_t alu_in2_sel;
		cmp_op_t      cmp_op;
		wr_sel_t      wr_sel;
		logic         dmem_we;
		logic         dmem_re;
		logic         is_jump;
		logic         is_ecall;
	} decode_t;

	// ##########################################################################
	// Stage registers
	// ##########################################################################

	typedef struct packed {
		logic [31:0] pc;
		instr_t      instr;
		logic        valid;
	} pipeline_id_reg_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		logic [31:0] csr_out;
		decode_t     dec;
		logic        valid;
	} pipeline_ex_reg_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        regfile_we;
		wr_sel_t     wr_sel;
		logic        dmem_we;
		logic        dmem_re;
		logic        is_ecall;
		logic [31:0] alu_out;
		logic [31:0] rs2_data;
		logic        taken;
		logic        valid;
	} pipeline_mem_reg_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        regfile_we;
		wr_sel_t     wr_sel;
		logic        is_ecall;
		logic [31:0] alu_out;
		logic [31:0] dmem_rdata;
		logic        taken;
		logic        valid;
	} pipeline_wb_reg_t;

	typedef struct packed {
		logic         pc_stall;
		logic         id_stall;
		logic         id_valid;
		logic         ex_valid;
		logic         mem_valid;
		bypass_t      bypass1;
		bypass_t      bypass2;
		next_pc_sel_t next_pc_sel;
		decode_t      decode_out;
	} pipeline_control_t;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/10ps

module regfile (
	input  logic        clk_i,
	input  logic [4:0]  rd_addr1_i,
	input  logic [4:0]  rd_addr2_i,
	input  logic [4:0]  wr_addr_i,
	input  logic [31:0] wr_data_i,
	input  logic        wr_en_i,
	output logic [31:0] rd_data1_o,
	output logic [31:0] rd_data2_o
);
	logic [31:0] regs [32];

	always_ff @(posedge clk_i) begin
		if (wr_en_i && wr_addr_i != 5'd0)
			regs[wr_addr_i] <= wr_data_i;
	end

	// x0 reads as zero.
	assign rd_data1_o = (rd_addr1_i == 5'd0) ? 32'd0 : regs[rd_addr1_i];
	assign rd_data2_o = (rd_addr2_i == 5'd0) ? 32'd0 : regs[rd_addr2_i];

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu (
	input  core_pkg::alu_op_t alu_op_i,
	input  core_pkg::cmp_op_t cmp_op_i,
	input  logic [31:0]       in1_i,
	input  logic [31:0]       in2_i,
	input  logic [31:0]       a1_i,
	input  logic [31:0]       a2_i,
	output logic [31:0]       out_o,
	output logic              taken_o
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = in2_i[4:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD:   out_o = in1_i + in2_i;
			ALU_SUB:   out_o = in1_i - in2_i;
			ALU_AND:   out_o = in1_i & in2_i;
			ALU_OR:    out_o = in1_i | in2_i;
			ALU_XOR:   out_o = in1_i ^ in2_i;
			ALU_SLT:   out_o = {31'd0, $signed(in1_i) < $signed(in2_i)};
			ALU_SLTU:  out_o = {31'd0, in1_i < in2_i};
			ALU_SLL:   out_o = in1_i << shamt;
			ALU_SRL:   out_o = in1_i >> shamt;
			ALU_SRA:   out_o = $signed(in1_i) >>> shamt;
			ALU_PASS2: out_o = in2_i;
			default:   out_o = 32'd0;
		endcase
	end

	// Branch condition on the register operands, not the ALU inputs.
	always_comb begin
		case (cmp_op_i)
			CMP_EQ:     taken_o = a1_i == a2_i;
			CMP_NE:     taken_o = a1_i != a2_i;
			CMP_LT:     taken_o = $signed(a1_i) < $signed(a2_i);
			CMP_GE:     taken_o = $signed(a1_i) >= $signed(a2_i);
			CMP_LTU:    taken_o = a1_i < a2_i;
			CMP_GEU:    taken_o = a1_i >= a2_i;
			CMP_ALWAYS: taken_o = 1'b1;
			default:    taken_o = 1'b0;
		endcase
	end

endmodule

//--- rtl/immediate.sv
`timescale 1ns/10ps

module immediate (
	input  core_pkg::instr_t instr_i,
	output logic [31:0]      imm_o
);
	import core_pkg::*;

	always_comb begin
		case (instr_i.common.opcode)
			OPCODE_OP_IMM, OPCODE_JALR, OPCODE_LOAD, OPCODE_SYSTEM:
				imm_o = {{20{instr_i.itype.imm[11]}}, instr_i.itype.imm};
			OPCODE_STORE:
				imm_o = {{20{instr_i.stype.imm_hi[6]}}, instr_i.stype.imm_hi,
					instr_i.stype.imm_lo};
			OPCODE_BRANCH:
				imm_o = {{20{instr_i.btype.imm_12}}, instr_i.btype.imm_11,
					instr_i.btype.imm_10_5, instr_i.btype.imm_4_1, 1'b0};
			OPCODE_LUI, OPCODE_AUIPC:
				imm_o = {instr_i.utype.imm, 12'd0};
			OPCODE_JAL:
				imm_o = {{12{instr_i.jtype.imm_20}}, instr_i.jtype.imm_19_12,
					instr_i.jtype.imm_11, instr_i.jtype.imm_10_1, 1'b0};
			default:
				imm_o = 32'd0;
		endcase
	end

endmodule

//--- rtl/csr.sv
`timescale 1ns/10ps

module csr (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [11:0] rd_addr_i,
	input  logic        instret_i,
	output logic [31:0] rd_data_o
);
	logic [31:0] cycle_q;
	logic [31:0] instret_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cycle_q   <= 32'd0;
			instret_q <= 32'd0;
		end else begin
			cycle_q <= cycle_q + 32'd1;
			if (instret_i)
				instret_q <= instret_q + 32'd1;
		end
	end

	// User and machine views read the same counters.
	always_comb begin
		case (rd_addr_i)
			12'hC00, 12'hB00: rd_data_o = cycle_q;
			12'hC02, 12'hB02: rd_data_o = instret_q;
			default:          rd_data_o = 32'd0;
		endcase
	end

endmodule

//--- rtl/control.sv
`timescale 1ns/10ps

module control (
	input  core_pkg::pipeline_id_reg_t  id_reg_i,
	input  core_pkg::pipeline_ex_reg_t  ex_reg_i,
	input  core_pkg::pipeline_mem_reg_t mem_reg_i,
	input  core_pkg::pipeline_wb_reg_t  wb_reg_i,
	output core_pkg::pipeline_control_t control_o
);
	import core_pkg::*;

	instr_t  instr;
	decode_t dec;
	logic    known;
	logic    uses_rs1;
	logic    uses_rs2;
	logic    flush;
	logic    halt;
	logic    load_use;

	function automatic alu_op_t alu_from_funct(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// Youngest valid writer of rs wins.
	function automatic bypass_t pick_bypass(input logic [4:0] rs);
		if (rs == 5'd0)
			return BYPASS_NONE;
		if (ex_reg_i.valid && ex_reg_i.dec.regfile_we && ex_reg_i.rd == rs)
			return BYPASS_EX;
		if (mem_reg_i.valid && mem_reg_i.regfile_we && mem_reg_i.rd == rs)
			return BYPASS_MEM;
		if (wb_reg_i.valid && wb_reg_i.regfile_we && wb_reg_i.rd == rs)
			return BYPASS_WB;
		return BYPASS_NONE;
	endfunction

	function automatic logic reads_rd(input logic [4:0] rd);
		return rd != 5'd0 &&
			((uses_rs1 && rd == instr.common.rs1) || (uses_rs2 && rd == instr.common.rs2));
	endfunction

	assign instr = id_reg_i.instr;

	// ##########################################################################
	// Decode
	// ##########################################################################

	always_comb begin
		dec.regfile_we  = 1'b0;
		dec.alu_op      = ALU_ADD;
		dec.alu_in1_sel = ALU_IN1_SEL_REGFILE_OUT1;
		dec.alu_in2_sel = ALU_IN2_SEL_REGFILE_OUT2;
		dec.cmp_op      = CMP_NEVER;
		dec.wr_sel      = WR_SEL_ALU_OUT;
		dec.dmem_we     = 1'b0;
		dec.dmem_re     = 1'b0;
		dec.is_jump     = 1'b0;
		dec.is_ecall    = 1'b0;
		known           = 1'b1;
		case (instr.common.opcode)
			OPCODE_OP: begin
				dec.regfile_we = 1'b1;
				dec.alu_op     = alu_from_funct(instr.common.funct3, instr.common.funct7[5]);
			end
			OPCODE_OP_IMM: begin
				dec.regfile_we  = 1'b1;
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
				dec.alu_op      = alu_from_funct(instr.common.funct3,
					instr.common.funct3 == 3'b101 && instr.common.funct7[5]);
			end
			OPCODE_LUI: begin
				dec.regfile_we  = 1'b1;
				dec.alu_op      = ALU_PASS2;
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
			end
			OPCODE_AUIPC: begin
				dec.regfile_we  = 1'b1;
				dec.alu_in1_sel = ALU_IN1_SEL_PC;
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
			end
			OPCODE_JAL: begin
				dec.is_jump     = 1'b1;
				dec.alu_in1_sel = ALU_IN1_SEL_PC;
			end
			OPCODE_JALR:
				dec.is_jump = 1'b1;
			OPCODE_BRANCH: begin
				dec.alu_in1_sel = ALU_IN1_SEL_PC;
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
				dec.cmp_op      = cmp_op_t'(instr.btype.funct3);
				known           = instr.btype.funct3[2:1] != 2'b01;
			end
			OPCODE_LOAD: begin
				dec.regfile_we  = 1'b1;
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
				dec.dmem_re     = 1'b1;
				dec.wr_sel      = WR_SEL_DMEM_RD_DATA;
			end
			OPCODE_STORE: begin
				dec.alu_in2_sel = ALU_IN2_SEL_IMM;
				dec.dmem_we     = 1'b1;
			end
			OPCODE_SYSTEM: begin
				if (instr.itype.funct3 == 3'b000) begin
					dec.is_ecall = instr.itype.imm == 12'd0;
					known        = dec.is_ecall;
				end else begin
					// csrrs read only.
					dec.regfile_we  = 1'b1;
					dec.alu_op      = ALU_PASS2;
					dec.alu_in2_sel = ALU_IN2_SEL_CSR_OUT;
				end
			end
			default:
				known = 1'b0;
		endcase
		// Jumps add their offset and link pc+4.
		if (dec.is_jump) begin
			dec.regfile_we  = 1'b1;
			dec.alu_in2_sel = ALU_IN2_SEL_IMM;
			dec.cmp_op      = CMP_ALWAYS;
			dec.wr_sel      = WR_SEL_PC_4;
		end
	end

	assign uses_rs1 = !(instr.common.opcode inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL});
	assign uses_rs2 = instr.common.opcode inside {OPCODE_OP, OPCODE_BRANCH, OPCODE_STORE};

	// ##########################################################################
	// Hazards
	// ##########################################################################

	assign flush = mem_reg_i.valid && mem_reg_i.taken;

	assign halt = (ex_reg_i.valid && ex_reg_i.dec.is_ecall) ||
		(mem_reg_i.valid && mem_reg_i.is_ecall) || (wb_reg_i.valid && wb_reg_i.is_ecall);

	// Load data is only forwarded from WB.
	assign load_use = id_reg_i.valid &&
		((ex_reg_i.valid && ex_reg_i.dec.dmem_re && reads_rd(ex_reg_i.rd)) ||
		(mem_reg_i.valid && mem_reg_i.dmem_re && reads_rd(mem_reg_i.rd)));

	always_comb begin
		control_o.pc_stall    = !flush && (halt || load_use);
		control_o.id_stall    = !flush && (halt || load_use);
		control_o.id_valid    = !flush;
		control_o.ex_valid    = !flush && !halt && !load_use && id_reg_i.valid && known;
		control_o.mem_valid   = !flush && ex_reg_i.valid;
		control_o.bypass1     = pick_bypass(instr.common.rs1);
		control_o.bypass2     = pick_bypass(instr.common.rs2);
		control_o.next_pc_sel = flush ? NEXT_PC_SEL_ALU_OUT : NEXT_PC_SEL_PC_4;
		control_o.decode_out  = dec;
	end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/10ps

module datapath #(
	parameter logic [31:0] RESET_PC = 32'h0001_0000
) (
	input  logic             clk_i,
	input  logic             reset_i,
	output logic [31:0]      imem_addr_o,
	input  core_pkg::instr_t imem_data_i,
	output logic [31:0]      dmem_addr_o,
	output logic [31:0]      dmem_wdata_o,
	output logic             dmem_we_o,
	input  logic [31:0]      dmem_rdata_i,
	output logic             halted_o
);
	import core_pkg::*;

	logic [31:0] pc;
	logic [31:0] next_pc;

	pipeline_id_reg_t  id_reg;
	pipeline_id_reg_t  next_id_reg;
	pipeline_ex_reg_t  ex_reg;
	pipeline_ex_reg_t  next_ex_reg;
	pipeline_mem_reg_t mem_reg;
	pipeline_mem_reg_t next_mem_reg;
	pipeline_wb_reg_t  wb_reg;
	pipeline_wb_reg_t  next_wb_reg;

	pipeline_control_t ctrl;

	logic [31:0] id_rf_out1;
	logic [31:0] id_rf_out2;
	logic [31:0] ex_alu_in1;
	logic [31:0] ex_alu_in2;
	logic [31:0] ex_alu_out;
	logic        ex_taken;
	logic [31:0] wb_wr_data;
	logic        halted;

	// Newest value of a source register, taken from the youngest stage that writes it.
	function automatic logic [31:0] bypass_mux(input bypass_t sel, input logic [31:0] rf_val);
		case (sel)
			BYPASS_EX:  return ex_alu_out;
			BYPASS_MEM: return mem_reg.alu_out;
			BYPASS_WB:  return wb_wr_data;
			default:    return rf_val;
		endcase
	endfunction

	control i_control (
		.id_reg_i (id_reg),
		.ex_reg_i (ex_reg),
		.mem_reg_i(mem_reg),
		.wb_reg_i (wb_reg),
		.control_o(ctrl)
	);

	// ##########################################################################
	// IF
	// ##########################################################################

	// jalr clears bit 0 of its target.
	assign next_pc = (ctrl.next_pc_sel == NEXT_PC_SEL_ALU_OUT) ?
		{mem_reg.alu_out[31:1], 1'b0} : pc + 32'd4;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			pc <= RESET_PC;
		else if (!ctrl.pc_stall)
			pc <= next_pc;
	end

	assign imem_addr_o = pc;

	assign next_id_reg.pc    = pc;
	assign next_id_reg.instr = imem_data_i;
	assign next_id_reg.valid = ctrl.id_valid;

	// ##########################################################################
	// ID
	// ##########################################################################

	always_ff @(posedge clk_i) begin
		if (!ctrl.id_stall)
			id_reg <= next_id_reg;
		if (reset_i)
			id_reg.valid <= 1'b0;
	end

	regfile i_regfile (
		.clk_i     (clk_i),
		.rd_addr1_i(id_reg.instr.common.rs1),
		.rd_addr2_i(id_reg.instr.common.rs2),
		.wr_addr_i (wb_reg.rd),
		.wr_data_i (wb_wr_data),
		.wr_en_i   (wb_reg.valid && wb_reg.regfile_we),
		.rd_data1_o(id_rf_out1),
		.rd_data2_o(id_rf_out2)
	);

	// ecall is not counted as retired.
	csr i_csr (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rd_addr_i(id_reg.instr.itype.imm),
		.instret_i(wb_reg.valid && !wb_reg.is_ecall),
		.rd_data_o(next_ex_reg.csr_out)
	);

	immediate i_immediate (
		.instr_i(id_reg.instr),
		.imm_o  (next_ex_reg.imm)
	);

	always_comb begin
		next_ex_reg.pc       = id_reg.pc;
		next_ex_reg.rd       = id_reg.instr.common.rd;
		next_ex_reg.rs1_data = bypass_mux(ctrl.bypass1, id_rf_out1);
		next_ex_reg.rs2_data = bypass_mux(ctrl.bypass2, id_rf_out2);
		next_ex_reg.dec      = ctrl.decode_out;
		next_ex_reg.valid    = ctrl.ex_valid;
	end

	// ##########################################################################
	// EX
	// ##########################################################################

	always_ff @(posedge clk_i) begin
		ex_reg <= next_ex_reg;
		if (reset_i)
			ex_reg.valid <= 1'b0;
	end

	assign ex_alu_in1 = (ex_reg.dec.alu_in1_sel == ALU_IN1_SEL_PC) ? ex_reg.pc : ex_reg.rs1_data;

	always_comb begin
		case (ex_reg.dec.alu_in2_sel)
			ALU_IN2_SEL_IMM:     ex_alu_in2 = ex_reg.imm;
			ALU_IN2_SEL_CSR_OUT: ex_alu_in2 = ex_reg.csr_out;
			default:             ex_alu_in2 = ex_reg.rs2_data;
		endcase
	end

	alu i_alu (
		.alu_op_i(ex_reg.dec.alu_op),
		.cmp_op_i(ex_reg.dec.cmp_op),
		.in1_i   (ex_alu_in1),
		.in2_i   (ex_alu_in2),
		.a1_i    (ex_reg.rs1_data),
		.a2_i    (ex_reg.rs2_data),
		.out_o   (ex_alu_out),
		.taken_o (ex_taken)
	);

	always_comb begin
		next_mem_reg.pc         = ex_reg.pc;
		next_mem_reg.rd         = ex_reg.rd;
		next_mem_reg.regfile_we = ex_reg.dec.regfile_we;
		next_mem_reg.wr_sel     = ex_reg.dec.wr_sel;
		next_mem_reg.dmem_we    = ex_reg.dec.dmem_we;
		next_mem_reg.dmem_re    = ex_reg.dec.dmem_re;
		next_mem_reg.is_ecall   = ex_reg.dec.is_ecall;
		next_mem_reg.alu_out    = ex_alu_out;
		next_mem_reg.rs2_data   = ex_reg.rs2_data;
		next_mem_reg.taken      = ex_taken;
		next_mem_reg.valid      = ctrl.mem_valid;
	end

	// ##########################################################################
	// MEM
	// ##########################################################################

	always_ff @(posedge clk_i) begin
		mem_reg <= next_mem_reg;
		if (reset_i)
			mem_reg.valid <= 1'b0;
	end

	assign dmem_addr_o  = mem_reg.alu_out;
	assign dmem_wdata_o = mem_reg.rs2_data;
	assign dmem_we_o    = mem_reg.valid && mem_reg.dmem_we;

	always_comb begin
		next_wb_reg.pc         = mem_reg.pc;
		next_wb_reg.rd         = mem_reg.rd;
		next_wb_reg.regfile_we = mem_reg.regfile_we;
		next_wb_reg.wr_sel     = mem_reg.wr_sel;
		next_wb_reg.is_ecall   = mem_reg.is_ecall;
		next_wb_reg.alu_out    = mem_reg.alu_out;
		next_wb_reg.dmem_rdata = dmem_rdata_i;
		next_wb_reg.taken      = mem_reg.taken;
		next_wb_reg.valid      = mem_reg.valid;
	end

	// ##########################################################################
	// WB
	// ##########################################################################

	// The ecall stays parked in WB, which keeps the core halted.
	assign halted = wb_reg.valid && wb_reg.is_ecall;

	always_ff @(posedge clk_i) begin
		if (!halted)
			wb_reg <= next_wb_reg;
		if (reset_i)
			wb_reg.valid <= 1'b0;
	end

	always_comb begin
		case (wb_reg.wr_sel)
			WR_SEL_PC_4:         wb_wr_data = wb_reg.pc + 32'd4;
			WR_SEL_DMEM_RD_DATA: wb_wr_data = wb_reg.dmem_rdata;
			default:             wb_wr_data = wb_reg.alu_out;
		endcase
	end

	assign halted_o = halted;

endmodule

//--- bench/tb_datapath.sv
`timescale 1ns/10ps

module tb_datapath;

	localparam logic [31:0] RESET_PC = 32'h0001_0000;
	localparam int TIMEOUT_CYCLES = 400;
	localparam logic [31:0] MARKER = 32'h0000_05AD;
	localparam logic [31:0] C1 = 32'h1234_5678;
	localparam logic [31:0] C2 = 32'hFEDC_B7A9;
	localparam int JAL_IDX = 74;
	localparam int AUIPC_IDX = 77;
	localparam int JALR_IDX = 78;
	// Distance between the two instret reads and between the two cycle reads.
	localparam int INSTRET_DIST = 4;
	localparam int CYCLE_DIST = 6;

	logic        clk_i;
	logic        reset_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_data_i;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic        dmem_we_o;
	logic [31:0] dmem_rdata_i;
	logic        halted_o;

	logic [31:0] imem [128];
	logic [31:0] dmem [64];
	logic [31:0] imem_offset;
	int          errors;
	int          cycles;

	datapath #(
		.RESET_PC(RESET_PC)
	) i_datapath (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.imem_addr_o (imem_addr_o),
		.imem_data_i (imem_data_i),
		.dmem_addr_o (dmem_addr_o),
		.dmem_wdata_o(dmem_wdata_o),
		.dmem_we_o   (dmem_we_o),
		.dmem_rdata_i(dmem_rdata_i),
		.halted_o    (halted_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ##########################################################################
	// Memories
	// ##########################################################################

	// Fetches outside the program read as zero, which decodes as a bubble.
	assign imem_offset = imem_addr_o - RESET_PC;
	assign imem_data_i = (imem_offset < 32'd512) ? imem[imem_offset[8:2]] : 32'd0;
	assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

	always @(posedge clk_i) begin
		if (dmem_we_o && dmem_addr_o < 32'd256)
			dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
	end

	always @(posedge clk_i) begin
		if (reset_i)
			cycles <= 0;
		else
			cycles <= cycles + 1;
	end

	// ##########################################################################
	// Concurrent checks
	// ##########################################################################

	store_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
		dmem_we_o |-> dmem_addr_o < 32'd256)
	else begin
		errors++;
		$display("store to address %h lies outside the data memory", $sampled(dmem_addr_o));
	end

	no_wrong_path_store: assert property (@(posedge clk_i) disable iff (reset_i)
		dmem_we_o |-> dmem_wdata_o != MARKER)
	else begin
		errors++;
		$display("a wrong-path store of the marker reached memory at %h",
			$sampled(dmem_addr_o));
	end

	halt_holds: assert property (@(posedge clk_i) disable iff (reset_i)
		halted_o |=> halted_o && !dmem_we_o)
	else begin
		errors++;
		$display("core left the halted state or stored after ecall");
	end

	// ##########################################################################
	// Result checks
	// ##########################################################################

	task automatic compare_word(input string name, input int idx, input logic [31:0] expected);
		assert (dmem[idx] === expected)
		else begin
			errors++;
			$display("ERROR %s dmem[%0d] got %h expected %h", name, idx, dmem[idx], expected);
		end
	endtask

	task automatic expect_idle_outputs(input string when);
		assert (dmem_we_o === 1'b0 && halted_o === 1'b0)
		else begin
			errors++;
			$display("ERROR dmem_we_o/halted_o %s got %h/%h expected 0/0",
				when, dmem_we_o, halted_o);
		end
	endtask

	task automatic verify_results();
		logic signed [31:0] s2;
		s2 = C2;
		compare_word("add", 0, C1 + C2);
		compare_word("sub", 1, C1 - C2);
		compare_word("and", 2, C1 & C2);
		compare_word("or", 3, C1 | C2);
		compare_word("xor", 4, C1 ^ C2);
		compare_word("slt", 5, {31'd0, s2 < $signed(C1)});
		compare_word("sltu", 6, {31'd0, C2 < C1});
		compare_word("sll", 7, C1 << C2[4:0]);
		compare_word("srl", 8, C2 >> C1[4:0]);
		compare_word("sra", 9, s2 >>> C1[4:0]);
		compare_word("addi", 10, C1 + 32'hFFFF_FFFF);
		compare_word("andi", 11, C2 & 32'h0000_00F0);
		compare_word("sltiu", 12, {31'd0, C1 < 32'hFFFF_FFFF});
		compare_word("srai", 13, s2 >>> 4);
		compare_word("instret_delta", 14, INSTRET_DIST);
		assert (dmem[15] >= CYCLE_DIST && dmem[15] < 32'd1000)
		else begin
			errors++;
			$display("ERROR cycle_delta dmem[15] got %h expected at least %h",
				dmem[15], CYCLE_DIST);
		end
		compare_word("load_use_sum", 16, (C1 + C2) + C1);
		compare_word("not_taken_count", 17, 32'd6);
		compare_word("jal_link", 18, RESET_PC + 4 * JAL_IDX + 4);
		compare_word("jalr_link", 19, RESET_PC + 4 * JALR_IDX + 4);
		compare_word("auipc", 20, RESET_PC + 4 * AUIPC_IDX);
		// The marker slot keeps its fill value.
		compare_word("marker_slot", 50, 32'hA5A5_0000 | 32'd200);
	endtask

	// ##########################################################################
	// Main sequence
	// ##########################################################################

	initial begin
		errors = 0;
		reset_i = 1'b1;
		for (int i = 0; i < 128; i++)
			imem[i] = 32'd0;
		for (int i = 0; i < 64; i++)
			dmem[i] = 32'hA5A5_0000 | (i * 4);
		$readmemh("bench/program.hex", imem);

		@(negedge clk_i);
		expect_idle_outputs("during reset");
		@(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		expect_idle_outputs("after reset");
		// First fetch after reset comes from the reset vector.
		assert (imem_addr_o === RESET_PC)
		else begin
			errors++;
			$display("ERROR imem_addr_o got %h expected %h", imem_addr_o, RESET_PC);
		end

		while (!halted_o && cycles < TIMEOUT_CYCLES)
			@(negedge clk_i);

		if (!halted_o) begin
			errors++;
			$display("timeout: halted_o did not rise within %0d cycles", TIMEOUT_CYCLES);
		end else begin
			// Let the halt check run for a few more cycles.
			repeat (8) @(negedge clk_i);
			verify_results();
		end

		$display("errors: %0d after %0d cycles", errors, cycles);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- datapath.f
rtl/core_pkg.sv
rtl/regfile.sv
rtl/alu.sv
rtl/immediate.sv
rtl/csr.sv
rtl/control.sv
rtl/datapath.sv
bench/tb_datapath.sv

//--- bench/program.hex
// One RV32I instruction word per line, in hex, placed from RESET_PC upward.
// Constants, then every ALU op stored to its own word.
123450B7
FEDCB137
67808093
7A910113
002082B3
00502023
402082B3
00502223
0020F2B3
00502423
0020E2B3
00502623
0020C2B3
00502823
001122B3
00502A23
001132B3
00502C23
002092B3
00502E23
001152B3
02502023
401152B3
02502223
FFF08293
02502423
0F017293
02502623
FFF0B293
02502823
40415293
02502A23
// Counter reads.
C0002773
C02027F3
00100813
00180813
00180813
C02028F3
C0002973
40F888B3
03102C23
40E90933
03202E23
// Load followed by its use.
00002303
001303B3
04702023
// Branches, each taken once and not taken once.
00008413
5AD00493
00000513
00808463
0C902423
00208463
00150513
00209463
0C902423
00809463
00150513
00114463
0C902423
0020C463
00150513
0020D463
0C902423
00115463
00150513
0020E463
0C902423
00116463
00150513
00117463
0C902423
0020F463
00150513
04A02223
// Jumps, auipc and ecall.
008005EF
0C902423
04B02423
00000617
00C606E7
0C902423
04D02623
04C02823
00000073
